/* Bender.yml */
package:
  name: rmii_rx_port

dependencies: {}

sources:
  - eth_pkg.sv
  - bus_pkg.sv
  - rmii_byte_packager.sv
  - fcs_checker.sv
  - frame_store.sv
  - wb_rx_port.sv
  - rmii_rx_port.sv
  - target: simulation
    files:
      - tb_rmii_rx_port.sv

/* bus_pkg.sv */
package bus_pkg;

    typedef logic [1:0]  wb_adr_t;
    typedef logic [31:0] wb_dat_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    ////////////////////////////////////////
    // Register map
    ////////////////////////////////////////

    localparam wb_adr_t REG_STATUS = 2'd0;
    localparam wb_adr_t REG_DATA   = 2'd1;

    // Fields of the REG_DATA word
    localparam int DATA_VALID_BIT = 9;
    localparam int DATA_LAST_BIT  = 8;

endpackage

/* eth_pkg.sv */
package eth_pkg;

    ////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////

    typedef logic [1:0]  dibit_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] fcs_t;
    typedef logic [10:0] store_addr_t;
    typedef logic [7:0]  frame_count_t;

    // Packager output
    typedef struct packed {
        logic  valid;
        logic  last;
        logic  error;
        byte_t data;
    } rx_beat_t;

    // Checker output, good only counts on the last beat
    typedef struct packed {
        logic  valid;
        logic  last;
        logic  good;
        byte_t data;
    } chk_beat_t;

    typedef struct packed {
        logic  last;
        byte_t data;
    } store_word_t;

    ////////////////////////////////////////
    // Framing constants
    ////////////////////////////////////////

    localparam dibit_t PREAMBLE_DIBIT     = 2'b01;
    localparam dibit_t SFD_DIBIT          = 2'b11;
    localparam fcs_t   FCS_INIT           = 32'hFFFF_FFFF;
    localparam fcs_t   FCS_POLY_REFLECTED = 32'hEDB8_8320;
    // Register value after a correct frame, no final inversion
    localparam fcs_t   FCS_RESIDUE        = 32'hDEBB_20E3;
    localparam int     FCS_BYTES          = 4;
    localparam int     MIN_FRAME_BYTES    = 64;
    localparam int     STORE_DEPTH        = 2048;
    localparam int     MAX_FRAMES         = 255;

endpackage

/* fcs_checker.sv */
`timescale 1ns/1ps

module fcs_checker (
    input  logic               clock,
    input  logic               rst_n,
    input  eth_pkg::rx_beat_t  in_beat,
    output eth_pkg::chk_beat_t out_beat
);

    eth_pkg::fcs_t                               crc;
    eth_pkg::fcs_t                               crc_next;
    logic [$clog2(eth_pkg::MIN_FRAME_BYTES):0]   length;
    logic [$clog2(eth_pkg::FCS_BYTES):0]         held_count;
    logic                                        full;
    logic                                        err_seen;
    logic                                        residue_ok;
    logic                                        length_ok;
    eth_pkg::byte_t                              delay [eth_pkg::FCS_BYTES];
    logic                                        out_valid;
    logic                                        out_last;
    logic                                        out_good;
    eth_pkg::byte_t                              out_data;

    // Reflected CRC-32 over one byte
    function automatic eth_pkg::fcs_t crc_byte(eth_pkg::fcs_t crc_in, eth_pkg::byte_t data);
        eth_pkg::fcs_t c;
        c = crc_in ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ eth_pkg::FCS_POLY_REFLECTED;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next   = crc_byte(crc, in_beat.data);
    assign full       = (held_count == eth_pkg::FCS_BYTES);
    assign residue_ok = (crc_next == eth_pkg::FCS_RESIDUE);
    // length does not yet include the byte on the input
    assign length_ok  = (length >= eth_pkg::MIN_FRAME_BYTES - 1);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            crc        <= eth_pkg::FCS_INIT;
            length     <= '0;
            held_count <= '0;
            err_seen   <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            out_good   <= 1'b0;
        end else begin
            out_valid <= in_beat.valid && full;
            out_last  <= in_beat.valid && in_beat.last && full;
            out_good  <= residue_ok && length_ok && !(err_seen || in_beat.error);
            if (in_beat.valid) begin
                if (in_beat.last) begin
                    crc        <= eth_pkg::FCS_INIT;
                    length     <= '0;
                    held_count <= '0;
                    err_seen   <= 1'b0;
                end else begin
                    crc      <= crc_next;
                    err_seen <= err_seen | in_beat.error;
                    if (length < eth_pkg::MIN_FRAME_BYTES) begin
                        length <= length + 1'b1;
                    end
                    if (!full) begin
                        held_count <= held_count + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Delay line strips the FCS
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (in_beat.valid) begin
            out_data <= delay[eth_pkg::FCS_BYTES-1];
            delay[0] <= in_beat.data;
            for (int i = 1; i < eth_pkg::FCS_BYTES; i++) begin
                delay[i] <= delay[i-1];
            end
        end
    end

    assign out_beat = '{valid: out_valid, last: out_last, good: out_good, data: out_data};

    a_last_needs_full: assert property (
        @(posedge clock) disable iff (!rst_n)
        out_last |-> $past(length) >= eth_pkg::FCS_BYTES
    );

endmodule

/* filelist.f */
eth_pkg.sv
bus_pkg.sv
rmii_byte_packager.sv
fcs_checker.sv
frame_store.sv
wb_rx_port.sv
rmii_rx_port.sv
tb_rmii_rx_port.sv

/* frame_store.sv */
`timescale 1ns/1ps

module frame_store (
    input  logic                  clock,
    input  logic                  rst_n,
    input  eth_pkg::chk_beat_t    in_beat,
    input  logic                  pop,
    output eth_pkg::store_word_t  head,
    output logic                  head_valid,
    output eth_pkg::frame_count_t frame_count
);

    eth_pkg::store_word_t mem [eth_pkg::STORE_DEPTH];
    eth_pkg::store_addr_t wr_ptr;
    eth_pkg::store_addr_t wr_ptr_next;
    eth_pkg::store_addr_t commit_ptr;
    eth_pkg::store_addr_t rd_ptr;
    logic                 dropping;
    logic                 overflow;
    logic                 at_max;
    logic                 drop_now;
    logic                 write_en;
    logic                 commit_frame;
    logic                 release_frame;

    assign wr_ptr_next   = wr_ptr + 1'b1;
    // One slot stays free so full and empty differ
    assign overflow      = (wr_ptr_next == rd_ptr);
    assign at_max        = (frame_count == eth_pkg::MAX_FRAMES);
    assign drop_now      = dropping || overflow || at_max;
    assign write_en      = in_beat.valid && !drop_now;
    assign commit_frame  = write_en && in_beat.last && in_beat.good;
    assign release_frame = pop && head.last;

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            dropping   <= 1'b0;
        end else if (in_beat.valid) begin
            if (drop_now) begin
                wr_ptr   <= commit_ptr;
                dropping <= !in_beat.last;
            end else if (in_beat.last) begin
                if (in_beat.good) begin
                    wr_ptr     <= wr_ptr_next;
                    commit_ptr <= wr_ptr_next;
                end else begin
                    // Rewind over the bad frame
                    wr_ptr <= commit_ptr;
                end
            end else begin
                wr_ptr <= wr_ptr_next;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[wr_ptr] <= '{last: in_beat.last, data: in_beat.data};
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            frame_count <= '0;
        end else if (commit_frame && !release_frame) begin
            frame_count <= frame_count + 1'b1;
        end else if (release_frame && !commit_frame) begin
            frame_count <= frame_count - 1'b1;
        end
    end

    // Fall-through head word
    assign head       = mem[rd_ptr];
    assign head_valid = (commit_ptr != rd_ptr);

    a_pop_when_valid: assert property (
        @(posedge clock) disable iff (!rst_n)
        pop |-> head_valid
    );

endmodule

/* rmii_byte_packager.sv */
`timescale 1ns/1ps

module rmii_byte_packager (
    input  logic              clock,
    input  logic              rst_n,
    input  eth_pkg::dibit_t   rmii_receive_data,
    input  logic              rmii_receive_data_enable,
    input  logic              rmii_receive_data_error,
    output eth_pkg::rx_beat_t beat
);

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        DATA
    } state_t;

    state_t         state;
    logic [1:0]     dibit_count;
    eth_pkg::byte_t shift_reg;
    eth_pkg::byte_t next_byte;
    eth_pkg::byte_t held_byte;
    logic           held_valid;
    logic           frame_error;
    logic           byte_done;
    logic           frame_end;
    logic           beat_valid;
    logic           beat_last;
    logic           beat_error;
    eth_pkg::byte_t beat_data;

    // Dibits arrive LSB first
    assign next_byte = {rmii_receive_data, shift_reg[7:2]};
    assign byte_done = (state == DATA) && rmii_receive_data_enable && (dibit_count == 2'd3);
    assign frame_end = (state == DATA) && !rmii_receive_data_enable;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= IDLE;
            dibit_count <= 2'd0;
            held_valid  <= 1'b0;
            frame_error <= 1'b0;
            beat_valid  <= 1'b0;
            beat_last   <= 1'b0;
            beat_error  <= 1'b0;
        end else begin
            beat_valid <= 1'b0;
            beat_last  <= 1'b0;
            case (state)
                IDLE: begin
                    dibit_count <= 2'd0;
                    held_valid  <= 1'b0;
                    frame_error <= 1'b0;
                    if (rmii_receive_data_enable &&
                        rmii_receive_data == eth_pkg::PREAMBLE_DIBIT) begin
                        state <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    if (!rmii_receive_data_enable) begin
                        state <= IDLE;
                    end else if (rmii_receive_data == eth_pkg::SFD_DIBIT) begin
                        state <= DATA;
                    end else if (rmii_receive_data != eth_pkg::PREAMBLE_DIBIT) begin
                        state <= IDLE;
                    end
                end
                DATA: begin
                    if (rmii_receive_data_enable) begin
                        dibit_count <= dibit_count + 2'd1;
                        if (rmii_receive_data_error) begin
                            frame_error <= 1'b1;
                        end
                        // Ship the held byte once the next one is complete
                        if (dibit_count == 2'd3) begin
                            held_valid <= 1'b1;
                            beat_valid <= held_valid;
                            beat_error <= frame_error | rmii_receive_data_error;
                        end
                    end else begin
                        // Partial trailing byte is dropped here
                        beat_valid <= held_valid;
                        beat_last  <= held_valid;
                        beat_error <= frame_error;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rmii_receive_data_enable) begin
            shift_reg <= next_byte;
        end
        if (byte_done) begin
            held_byte <= next_byte;
        end
        if (byte_done || frame_end) begin
            beat_data <= held_byte;
        end
    end

    assign beat = '{valid: beat_valid, last: beat_last, error: beat_error, data: beat_data};

    a_valid_in_frame: assert property (
        @(posedge clock) disable iff (!rst_n)
        beat_valid |-> $past(state) == DATA
    );

endmodule

/* rmii_rx_port.sv */
`timescale 1ns/1ps

module rmii_rx_port (
    input  logic              clock,
    input  logic              rst_n,
    input  eth_pkg::dibit_t   rmii_receive_data,
    input  logic              rmii_receive_data_enable,
    input  logic              rmii_receive_data_error,
    input  bus_pkg::wb_req_t  wb_req,
    output bus_pkg::wb_rsp_t  wb_rsp
);

    eth_pkg::rx_beat_t     packager_beat;
    eth_pkg::chk_beat_t    checker_beat;
    eth_pkg::store_word_t  head;
    logic                  head_valid;
    eth_pkg::frame_count_t frame_count;
    logic                  pop;

    ////////////////////////////////////////
    // Receive pipeline
    ////////////////////////////////////////

    rmii_byte_packager u_packager (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .beat                     (packager_beat)
    );

    fcs_checker u_checker (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_beat  (packager_beat),
        .out_beat (checker_beat)
    );

    frame_store u_store (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_beat     (checker_beat),
        .pop         (pop),
        .head        (head),
        .head_valid  (head_valid),
        .frame_count (frame_count)
    );

    // Host side
    wb_rx_port u_bus (
        .clock       (clock),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .head        (head),
        .head_valid  (head_valid),
        .frame_count (frame_count),
        .pop         (pop)
    );

endmodule

/* tb_rmii_rx_port.sv */
`timescale 1ns/1ps

module tb_rmii_rx_port;

    localparam int BUS_TIMEOUT = 20;
    localparam int IDLE_GAP    = 12;

    logic              clock;
    logic              rst_n;
    eth_pkg::dibit_t   rmii_receive_data;
    logic              rmii_receive_data_enable;
    logic              rmii_receive_data_error;
    bus_pkg::wb_req_t  wb_req;
    bus_pkg::wb_rsp_t  wb_rsp;

    int                seed;
    int                frames_waiting;
    eth_pkg::byte_t    frame_buf [0:1023];
    logic [8:0]        expected_q [$];

    rmii_rx_port u_dut (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .rmii_receive_data        (rmii_receive_data),
        .rmii_receive_data_enable (rmii_receive_data_enable),
        .rmii_receive_data_error  (rmii_receive_data_error),
        .wb_req                   (wb_req),
        .wb_rsp                   (wb_rsp)
    );

    always #4 clock = ~clock;

    ////////////////////////////////////////
    // Reference and checks
    ////////////////////////////////////////

    // Ethernet FCS of frame_buf[0 .. len-1] as sent on the wire
    function automatic eth_pkg::fcs_t reference_fcs(input int len);
        eth_pkg::fcs_t c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            c = c ^ {24'd0, frame_buf[i]};
            for (int j = 0; j < 8; j++) begin
                c = c[0] ? ((c >> 1) ^ eth_pkg::FCS_POLY_REFLECTED) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // Compares every valid byte read from REG_DATA with the queued payload
    always @(negedge clock) begin
        if (rst_n && wb_rsp.ack && !wb_req.we && wb_req.adr == bus_pkg::REG_DATA &&
            wb_rsp.dat[bus_pkg::DATA_VALID_BIT]) begin
            if (expected_q.size() == 0) begin
                $display("Data read returned a valid byte while no byte was expected");
                $display("TB FAILED");
                $fatal(1);
            end else begin
                check_value("data word", {23'd0, wb_rsp.dat[8:0]}, {23'd0, expected_q.pop_front()});
            end
        end
    end

    ////////////////////////////////////////
    // RMII side
    ////////////////////////////////////////

    task automatic send_byte(input eth_pkg::byte_t b, input logic err);
        for (int k = 0; k < 4; k++) begin
            @(negedge clock);
            rmii_receive_data_enable = 1'b1;
            rmii_receive_data        = b[2*k +: 2];
            rmii_receive_data_error  = err && (k == 1);
        end
    endtask

    // error_at indexes the frame bytes and is -1 for a clean frame
    task automatic send_frame(input int len, input logic corrupt, input int error_at,
                              input logic kept);
        eth_pkg::fcs_t fcs;
        int            r;
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            frame_buf[i] = r[7:0];
        end
        fcs = reference_fcs(len);
        if (corrupt) begin
            fcs[13] = ~fcs[13];
        end
        for (int i = 0; i < 4; i++) begin
            frame_buf[len+i] = fcs[8*i +: 8];
        end
        if (kept) begin
            for (int i = 0; i < len; i++) begin
                expected_q.push_back({i == len - 1, frame_buf[i]});
            end
            frames_waiting++;
        end
        repeat (7) send_byte(8'h55, 1'b0);
        send_byte(8'hD5, 1'b0);
        for (int i = 0; i < len + 4; i++) begin
            send_byte(frame_buf[i], i == error_at);
        end
        @(negedge clock);
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data        = 2'b00;
        rmii_receive_data_error  = 1'b0;
        repeat (IDLE_GAP) @(negedge clock);
    endtask

    ////////////////////////////////////////
    // Wishbone side
    ////////////////////////////////////////

    // Hold keeps cyc and stb up for extra cycles after ack
    task automatic bus_access(input logic we, input bus_pkg::wb_adr_t adr, input int hold,
                              output bus_pkg::wb_dat_t data);
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = we ? 32'hA5A5_5A5A : 32'd0;
        @(negedge clock);
        waited = 1;
        while (!wb_rsp.ack) begin
            if (waited >= BUS_TIMEOUT) begin
                $display("Timeout: no Wishbone ack within %0d cycles", BUS_TIMEOUT);
                $display("TB FAILED");
                $fatal(1);
            end
            @(negedge clock);
            waited++;
        end
        check_value("ack latency in cycles", waited, 1);
        data = wb_rsp.dat;
        repeat (hold) begin
            @(negedge clock);
            check_value("ack while strobe held", {31'd0, wb_rsp.ack}, 0);
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        @(negedge clock);
        check_value("ack after release", {31'd0, wb_rsp.ack}, 0);
    endtask

    task automatic read_reg(input bus_pkg::wb_adr_t adr, output bus_pkg::wb_dat_t data);
        bus_access(1'b0, adr, 0, data);
    endtask

    task automatic check_status();
        bus_pkg::wb_dat_t s;
        read_reg(bus_pkg::REG_STATUS, s);
        check_value("REG_STATUS frame count", s, frames_waiting);
    endtask

    task automatic drain_bytes(input int n);
        bus_pkg::wb_dat_t d;
        for (int i = 0; i < n; i++) begin
            read_reg(bus_pkg::REG_DATA, d);
            check_value("data valid bit", {31'd0, d[bus_pkg::DATA_VALID_BIT]}, 1);
            if (d[bus_pkg::DATA_LAST_BIT]) begin
                frames_waiting--;
                check_status();
            end
        end
        read_reg(bus_pkg::REG_DATA, d);
        check_value("data valid after drain", {31'd0, d[bus_pkg::DATA_VALID_BIT]}, 0);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        bus_pkg::wb_dat_t d;
        clock                    = 1'b0;
        rst_n                    = 1'b0;
        rmii_receive_data        = 2'b00;
        rmii_receive_data_enable = 1'b0;
        rmii_receive_data_error  = 1'b0;
        wb_req                   = '0;
        seed                     = 85;
        frames_waiting           = 0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        repeat (2) @(negedge clock);
        check_status();

        // Minimum size frame and a longer one
        send_frame(60, 1'b0, -1, 1'b1);
        check_status();
        send_frame(200, 1'b0, -1, 1'b1);
        check_status();
        drain_bytes(260);

        // Bad FCS, receive error, runt, then a good frame
        send_frame(60, 1'b1, -1, 1'b0);
        check_status();
        send_frame(100, 1'b0, 30, 1'b0);
        check_status();
        send_frame(36, 1'b0, -1, 1'b0);
        check_status();
        send_frame(80, 1'b0, -1, 1'b1);
        check_status();
        drain_bytes(80);

        // Three queued frames, then an empty read
        send_frame(64, 1'b0, -1, 1'b1);
        send_frame(70, 1'b0, -1, 1'b1);
        send_frame(90, 1'b0, -1, 1'b1);
        check_status();
        drain_bytes(224);
        read_reg(bus_pkg::REG_DATA, d);
        check_value("empty REG_DATA read", d, 0);

        // Third large frame does not fit
        send_frame(1000, 1'b0, -1, 1'b1);
        send_frame(1000, 1'b0, -1, 1'b1);
        send_frame(1000, 1'b0, -1, 1'b0);
        check_status();
        drain_bytes(2000);

        // A write with a held strobe consumes nothing
        send_frame(60, 1'b0, -1, 1'b1);
        bus_access(1'b1, bus_pkg::REG_DATA, 2, d);
        check_status();
        drain_bytes(60);

        $display("TB PASSED");
        $finish;
    end

endmodule

/* wb_rx_port.sv */
`timescale 1ns/1ps

module wb_rx_port (
    input  logic                  clock,
    input  logic                  rst_n,
    input  bus_pkg::wb_req_t      wb_req,
    output bus_pkg::wb_rsp_t      wb_rsp,
    input  eth_pkg::store_word_t  head,
    input  logic                  head_valid,
    input  eth_pkg::frame_count_t frame_count,
    output logic                  pop
);

    logic             req;
    logic             req_q;
    logic             start;
    logic             ack;
    bus_pkg::wb_dat_t read_data;
    bus_pkg::wb_dat_t rsp_dat;

    assign req   = wb_req.cyc && wb_req.stb;
    // First cycle of a request only
    assign start = req && !req_q;

    always_comb begin
        read_data = '0;
        case (wb_req.adr)
            bus_pkg::REG_STATUS: read_data[7:0] = frame_count;
            bus_pkg::REG_DATA: begin
                if (head_valid) begin
                    read_data[7:0]                  = head.data;
                    read_data[bus_pkg::DATA_LAST_BIT]  = head.last;
                    read_data[bus_pkg::DATA_VALID_BIT] = 1'b1;
                end
            end
            default: read_data = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_q <= 1'b0;
            ack   <= 1'b0;
            pop   <= 1'b0;
        end else begin
            req_q <= req;
            ack   <= start;
            pop   <= start && !wb_req.we && (wb_req.adr == bus_pkg::REG_DATA) && head_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            rsp_dat <= wb_req.we ? '0 : read_data;
        end
    end

    assign wb_rsp = '{ack: ack, dat: rsp_dat};

    a_single_ack: assert property (
        @(posedge clock) disable iff (!rst_n)
        ack |=> !ack
    );

endmodule
